// File: bench/ad7794_model.sv
`timescale 1ns/1ps

module ad7794_model (
	input  logic sclk,
	input  logic cs,
	input  logic din,
	output logic dout
);

	logic [23:0] regs [0:7];
	logic [7:0]  comm;
	logic [23:0] shift_in;
	logic [23:0] shift_out;
	int          bit_cnt;

	initial begin
		for (int i = 0; i < 8; i++) begin
			regs[i] = 24'(i) * 24'h111111;  // preset is address times 0x111111.
		end
		comm      = '0;
		shift_in  = '0;
		shift_out = '0;
		bit_cnt   = 0;
		dout      = 1'b0;
	end

	// din is sampled on rising sclk, a frame restarts when cs goes high.
	always @(posedge sclk or posedge cs) begin
		if (cs) begin
			bit_cnt = 0;
		end else begin
			if (bit_cnt < 8) begin
				comm = {comm[6:0], din};  // communications byte first.
			end else begin
				shift_in = {shift_in[22:0], din};
			end
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 32 && !comm[6]) begin
				regs[comm[5:3]] = shift_in;  // register select in bits 5:3.
			end
		end
	end

	// dout changes on falling sclk so it is stable at the next rising edge.
	always @(negedge sclk) begin
		if (!cs) begin
			if (bit_cnt == 8) begin
				shift_out = comm[6] ? regs[comm[5:3]] : 24'h0;
			end else begin
				shift_out = {shift_out[22:0], 1'b0};
			end
			dout = shift_out[23];
		end
	end

endmodule

// File: bench/adc_sub_properties.sv
`timescale 1ns/1ps

module adc_sub_properties (
	input logic clkin,
	input logic reset,
	input logic CS,
	input logic SCLK,
	input logic DIN,
	input logic CLK,
	input logic sclk_in,
	input logic mosi_in,
	input logic spi_ssb_in,
	input logic spi_ssb_out,
	input logic adcclk,
	input logic busy,
	input logic host_done,
	input logic sample_valid,
	input logic spi_start,
	input logic spi_ready,
	input logic poll_enable
);

	int unsigned fail_count = 0;

	reset_state: assert property (@(posedge clkin)
		reset |=> CS && !SCLK && spi_ready && !busy && !host_done && !sample_valid)
	else begin
		$error("outputs left the reset state during reset");
		fail_count++;
	end

	ready_drop: assert property (@(posedge clkin) disable iff (reset)
		spi_start && spi_ready |=> !spi_ready)
	else begin
		$error("spi_ready did not drop after spi_start");
		fail_count++;
	end

	ready_rise: assert property (@(posedge clkin) disable iff (reset)
		$rose(spi_ready) |-> CS)
	else begin
		$error("spi_ready rose while CS was low");
		fail_count++;
	end

	// a poll frame is requested two cycles before CS falls.
	cs_cause: assert property (@(posedge clkin) disable iff (reset)
		$fell(CS) |-> $past(busy) || $past(poll_enable, 2))
	else begin
		$error("CS fell with no host command pending and polling disabled");
		fail_count++;
	end

	sclk_idle: assert property (@(posedge clkin) disable iff (reset)
		CS && spi_ssb_in |-> !SCLK)
	else begin
		$error("SCLK high while CS is high");
		fail_count++;
	end

	ext_route: assert property (@(posedge clkin) disable iff (reset)
		!spi_ssb_in |-> (SCLK == sclk_in) && (DIN == mosi_in))
	else begin
		$error("external master pins not routed to SCLK and DIN");
		fail_count++;
	end

	ssb_chain: assert property (@(posedge clkin) disable iff (reset)
		(spi_ssb_out == (spi_ssb_in & CS)) && (CLK == adcclk))
	else begin
		$error("chained select or ADC clock mismatch");
		fail_count++;
	end

endmodule

// File: bench/adc_sub_tb.sv
`timescale 1ns/1ps

module adc_sub_tb;
	import adc_pkg::*;

	localparam int tsck_half    = 1;
	localparam int clk_period   = 4;
	localparam int frame_cycles = 2 * tsck_half * 32 + 8;  // frame plus start and ready slack.
	localparam int watchdog_ns  = 200 * frame_cycles * clk_period;
	localparam int poll_period  = 20;

	logic        clkin;
	logic        reset;
	logic        cmd_strobe;
	host_cmd_t   host_cmd;
	logic        host_done;
	logic [23:0] host_rdata;
	logic        busy;
	logic        sample_valid;
	sample_t     sample;
	logic        CLK;
	logic        CS;
	logic        DIN;
	logic        DOUT_RDY;
	logic        SCLK;
	logic        sclk_in;
	logic        mosi_in;
	logic        spi_ssb_in;
	logic        spi_ssb_out;
	logic        adcclk;

	logic [23:0] mirror [0:7];  // expected ADC register contents.
	logic [7:0]  poll_addr_exp;
	logic        samples_allowed;
	int          sample_count;
	int          seed;

	adc_sub_top #(
		.tsck_half(tsck_half),
		.spi_mode ("chain")
	) i_adc_sub_top (
		.clkin       (clkin),
		.reset       (reset),
		.cmd_strobe  (cmd_strobe),
		.host_cmd    (host_cmd),
		.host_done   (host_done),
		.host_rdata  (host_rdata),
		.busy        (busy),
		.sample_valid(sample_valid),
		.sample      (sample),
		.CLK         (CLK),
		.CS          (CS),
		.DIN         (DIN),
		.DOUT_RDY    (DOUT_RDY),
		.SCLK        (SCLK),
		.sclk_in     (sclk_in),
		.mosi_in     (mosi_in),
		.spi_ssb_in  (spi_ssb_in),
		.spi_ssb_out (spi_ssb_out),
		.adcclk      (adcclk)
	);

	ad7794_model i_ad7794_model (
		.sclk(SCLK),
		.cs  (CS),
		.din (DIN),
		.dout(DOUT_RDY)
	);

	bind adc_sub_top adc_sub_properties i_adc_sub_properties (
		.clkin       (clkin),
		.reset       (reset),
		.CS          (CS),
		.SCLK        (SCLK),
		.DIN         (DIN),
		.CLK         (CLK),
		.sclk_in     (sclk_in),
		.mosi_in     (mosi_in),
		.spi_ssb_in  (spi_ssb_in),
		.spi_ssb_out (spi_ssb_out),
		.adcclk      (adcclk),
		.busy        (busy),
		.host_done   (host_done),
		.sample_valid(sample_valid),
		.spi_start   (spi_start),
		.spi_ready   (spi_ready),
		.poll_enable (cfg.poll_enable)
	);

	initial begin
		clkin = 1'b0;
		forever #(clk_period / 2) clkin = ~clkin;
	end

	initial begin
		adcclk = 1'b0;
		forever begin
			repeat (3) @(posedge clkin);
			#1 adcclk = ~adcclk;  // slower unrelated adc clock.
		end
	end

	task automatic abort_run(input string what);
		$display("%s at %0t", what, $time);
		$display("sim failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	function automatic logic [7:0] adc_addr(input logic [2:0] idx);
		return {2'b00, idx, 3'b000};  // register select sits in bits 5:3.
	endfunction

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clkin);
			n++;
		end while (!host_done && n < limit);
		if (!host_done) begin
			abort_run("host_done did not arrive in time");
		end
	endtask

	task automatic send_cmd(input target_t tgt, input logic rd, input logic [7:0] addr,
		input logic [23:0] data, output logic [23:0] rdata);
		int n;
		n = 0;
		@(negedge clkin);
		while (busy && n < 4 * frame_cycles) begin
			@(negedge clkin);
			n++;
		end
		if (busy) begin
			abort_run("busy never went low");
		end
		@(posedge clkin);
		#1;
		host_cmd   = '{target: tgt, read: rd, addr: addr, data: data};
		cmd_strobe = 1'b1;
		@(posedge clkin);
		#1;
		cmd_strobe = 1'b0;
		wait_done(4 * frame_cycles);
		rdata = host_rdata;
	endtask

	task automatic local_write(input logic [7:0] addr, input logic [23:0] data);
		logic [23:0] unused;
		send_cmd(tgt_local, 1'b0, addr, data, unused);
	endtask

	task automatic local_read(input logic [7:0] addr, input logic [23:0] exp);
		logic [23:0] rd;
		send_cmd(tgt_local, 1'b1, addr, 24'h0, rd);
		check_value("host_rdata", 32'(rd), 32'(exp));
	endtask

	task automatic adc_write(input logic [2:0] idx, input logic [23:0] data);
		logic [23:0] unused;
		send_cmd(tgt_adc, 1'b0, adc_addr(idx), data, unused);
		mirror[idx] = data;  // the frame has completed here.
	endtask

	task automatic adc_read(input logic [2:0] idx);
		logic [23:0] rd;
		send_cmd(tgt_adc, 1'b1, adc_addr(idx), 24'h0, rd);
		check_value("host_rdata", 32'(rd), 32'(mirror[idx]));
	endtask

	task automatic wait_samples(input int target);
		int n;
		n = 0;
		while (sample_count < target && n < 8 * (poll_period + frame_cycles)) begin
			@(negedge clkin);
			n++;
		end
		if (sample_count < target) begin
			abort_run("too few samples while polling");
		end
	endtask

	always @(negedge clkin) begin
		if (i_adc_sub_top.i_adc_sub_properties.fail_count != 0) begin
			abort_run("a bound assertion failed");
		end
		if (!reset && sample_valid) begin
			if (!samples_allowed) begin
				abort_run("sample_valid while polling is disabled");
			end
			check_value("sample.addr", 32'(sample.addr), 32'(poll_addr_exp));
			check_value("sample.value", 32'(sample.value), 32'(mirror[poll_addr_exp[5:3]]));
			sample_count++;
		end
	end

	initial begin
		#(watchdog_ns);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] r;
		logic [23:0] val;
		logic [7:0]  pa;
		logic [2:0]  idx;
		int          n;
		seed            = 32'h7544_6dcb;
		reset           = 1'b1;
		cmd_strobe      = 1'b0;
		host_cmd        = '0;
		sclk_in         = 1'b0;
		mosi_in         = 1'b0;
		spi_ssb_in      = 1'b1;
		samples_allowed = 1'b0;
		sample_count    = 0;
		poll_addr_exp   = '0;
		for (int i = 0; i < 8; i++) begin
			mirror[i] = 24'(i) * 24'h111111;
		end
		repeat (5) @(posedge clkin);
		#1;
		reset = 1'b0;
		@(negedge clkin);
		check_value("CS", 32'(CS), 32'd1);
		check_value("busy", 32'(busy), 32'd0);
		check_value("host_done", 32'(host_done), 32'd0);
		check_value("sample_valid", 32'(sample_valid), 32'd0);
		local_read(reg_ctrl, 24'h0);

		// local configuration registers.
		r  = $random(seed);
		pa = r[7:0];
		local_write(reg_poll_addr, {16'h0, pa});
		local_read(reg_poll_addr, {16'h0, pa});
		r   = $random(seed);
		val = r[23:0] | 24'h800000;  // long interval keeps polls away.
		local_write(reg_poll_interval, val);
		local_read(reg_poll_interval, val);
		local_write(reg_ctrl, 24'h1);
		local_read(reg_ctrl, 24'h1);
		local_write(reg_ctrl, 24'h0);
		local_read(reg_ctrl, 24'h0);

		// adc register writes and reads.
		adc_read(3'd5);
		repeat (4) begin
			r   = $random(seed);
			idx = r[2:0];
			r   = $random(seed);
			adc_write(idx, r[23:0]);
			adc_read(idx);
		end
		for (int i = 0; i < 8; i++) begin
			adc_read(i[2:0]);
		end

		// interval polling.
		r             = $random(seed);
		idx           = r[2:0];
		poll_addr_exp = adc_addr(idx);
		local_write(reg_poll_addr, {16'h0, poll_addr_exp});
		local_write(reg_poll_interval, 24'(poll_period));
		samples_allowed = 1'b1;
		local_write(reg_ctrl, 24'h1);
		wait_samples(sample_count + 3);
		r = $random(seed);
		adc_write(idx, r[23:0]);
		wait_samples(sample_count + 2);
		local_write(reg_ctrl, 24'h0);
		repeat (3) @(negedge clkin);
		n = 0;
		while (!CS && n < 2 * frame_cycles) begin
			@(negedge clkin);
			n++;
		end
		if (!CS) begin
			abort_run("CS stayed low after polling was disabled");
		end
		repeat (4) @(negedge clkin);  // last sample of a frame in flight.
		samples_allowed = 1'b0;
		repeat (4 * poll_period) @(negedge clkin);

		// external master owns the pins.
		@(posedge clkin);
		#1;
		spi_ssb_in = 1'b0;
		repeat (16) begin
			@(posedge clkin);
			#1;
			r       = $random(seed);
			sclk_in = r[0];
			mosi_in = r[1];
		end
		@(posedge clkin);
		#1;
		spi_ssb_in = 1'b1;
		sclk_in    = 1'b0;
		mosi_in    = 1'b0;

		repeat (4) @(negedge clkin);
		if (i_adc_sub_top.i_adc_sub_properties.fail_count != 0) begin
			$display("sim failed");
			$fatal(1, "bound assertions reported failures");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// File: project.f
src/spi_pkg.sv
src/adc_pkg.sv
src/spi_master.sv
src/ad7794.sv
src/adc_cfg_regs.sv
src/adc_poll_seq.sv
src/adc_sub_top.sv
bench/ad7794_model.sv
bench/adc_sub_properties.sv
bench/adc_sub_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module adc_sub_tb -o adc_sub_sim

if ! ./obj_dir/adc_sub_sim +verilator+error+limit+100 > sim.log 2>&1; then
	echo "simulator returned a non-zero status"
fi
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "RESULT: FAIL"
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "RESULT: FAIL (no result line in log)"
	exit 1
fi
echo "RESULT: PASS"

// File: src/ad7794.sv
`timescale 1ns/1ps

module ad7794 #(
	parameter int tsck_half = 1,
	parameter     spi_mode  = "chain"
) (
	input  logic              clkin,
	input  logic              reset,
	input  logic              spi_start,
	input  spi_pkg::spi_req_t req,
	output logic              spi_ready,
	output spi_pkg::spi_rsp_t rsp,
	output logic              sdio_as_sdo,
	output logic              CLK,
	output logic              CS,
	output logic              DIN,
	input  logic              DOUT_RDY,
	output logic              SCLK,
	input  logic              sclk_in,
	input  logic              mosi_in,
	input  logic              spi_ssb_in,
	output logic              spi_ssb_out,
	input  logic              adcclk
);

	logic cs_m;
	logic sck_m;
	logic sdi_m;

	generate
		if (spi_mode == "chain") begin : g_chain
			// external master owns sclk and din while its select is low.
			assign SCLK = spi_ssb_in ? sck_m : sclk_in;
			assign DIN  = spi_ssb_in ? sdi_m : mosi_in;
		end else begin : g_standalone
			assign SCLK = sck_m;  // any other mode value builds standalone.
			assign DIN  = sdi_m;
		end
	endgenerate

	assign CS  = cs_m;
	assign CLK = adcclk;  // adc master clock.
	assign spi_ssb_out = spi_ssb_in & CS;  // next device in the chain.

	spi_master #(
		.tsck_half(tsck_half)
	) i_spi_master (
		.clk        (clkin),
		.reset      (reset),
		.spi_start  (spi_start),
		.req        (req),
		.spi_ready  (spi_ready),
		.rsp        (rsp),
		.sdio_as_sdo(sdio_as_sdo),
		.cs         (cs_m),
		.sck        (sck_m),
		.sdi        (sdi_m),
		.sdo        (DOUT_RDY)
	);

endmodule

// File: src/adc_cfg_regs.sv
`timescale 1ns/1ps

module adc_cfg_regs (
	input  logic                           clkin,
	input  logic                           reset,
	input  logic                           cmd_strobe,
	input  adc_pkg::host_cmd_t             host_cmd,
	output adc_pkg::cfg_t                  cfg,
	output logic [adc_pkg::reg_data_w-1:0] host_rdata_local,
	output logic                           local_done
);
	import adc_pkg::*;

	logic local_cmd;

	assign local_cmd = cmd_strobe && (host_cmd.target == tgt_local);

	always_ff @(posedge clkin) begin
		if (reset) begin
			cfg        <= '0;  // polling off.
			local_done <= 1'b0;
		end else begin
			local_done <= local_cmd;
			if (local_cmd && !host_cmd.read) begin
				case (host_cmd.addr)
					reg_ctrl:          cfg.poll_enable <= host_cmd.data[0];
					reg_poll_addr:     cfg.poll_addr <= host_cmd.data[reg_addr_w-1:0];
					reg_poll_interval: cfg.poll_interval <=
						{{(poll_int_w - reg_data_w){1'b0}}, host_cmd.data};
					default: ;  // unmapped writes are dropped.
				endcase
			end
		end
	end

	always_ff @(posedge clkin) begin
		if (local_cmd) begin
			case (host_cmd.addr)
				reg_ctrl:          host_rdata_local <= {{(reg_data_w - 1){1'b0}}, cfg.poll_enable};
				reg_poll_addr:     host_rdata_local <=
					{{(reg_data_w - reg_addr_w){1'b0}}, cfg.poll_addr};
				reg_poll_interval: host_rdata_local <= cfg.poll_interval[reg_data_w-1:0];
				default:           host_rdata_local <= '0;
			endcase
		end
	end

endmodule

// File: src/adc_pkg.sv
package adc_pkg;

	localparam int reg_addr_w    = 8;
	localparam int reg_data_w    = 24;
	localparam int poll_int_w    = 32;
	localparam int comm_read_bit = 6;  // r/w marker in the ad7794 communications byte.

	// local register map.
	localparam logic [reg_addr_w-1:0] reg_ctrl          = 8'd0;  // bit 0 is poll enable.
	localparam logic [reg_addr_w-1:0] reg_poll_addr     = 8'd1;
	localparam logic [reg_addr_w-1:0] reg_poll_interval = 8'd2;

	typedef enum logic {
		tgt_local = 1'b0,
		tgt_adc   = 1'b1
	} target_t;

	typedef struct packed {
		target_t               target;
		logic                  read;
		logic [reg_addr_w-1:0] addr;
		logic [reg_data_w-1:0] data;
	} host_cmd_t;

	typedef struct packed {
		logic                  poll_enable;
		logic [reg_addr_w-1:0] poll_addr;
		logic [poll_int_w-1:0] poll_interval;  // in clkin cycles.
	} cfg_t;

	typedef struct packed {
		logic [reg_addr_w-1:0] addr;
		logic [reg_data_w-1:0] value;
	} sample_t;

endpackage

// File: src/adc_poll_seq.sv
`timescale 1ns/1ps

module adc_poll_seq (
	input  logic                           clkin,
	input  logic                           reset,
	input  logic                           cmd_strobe,
	input  adc_pkg::host_cmd_t             host_cmd,
	input  adc_pkg::cfg_t                  cfg,
	output logic                           spi_start,
	output spi_pkg::spi_req_t              req,
	input  logic                           spi_ready,
	input  spi_pkg::spi_rsp_t              rsp,
	output logic                           busy,
	output logic                           spi_done,
	output logic [adc_pkg::reg_data_w-1:0] spi_rdata,
	output logic                           sample_valid,
	output adc_pkg::sample_t               sample
);
	import spi_pkg::*;
	import adc_pkg::*;

	host_cmd_t             host_q;
	logic                  host_pend;
	logic                  poll_pend;
	logic                  in_flight;
	logic                  owner_poll;  // frame in flight belongs to the poller.
	logic                  ready_q;
	logic [poll_int_w-1:0] poll_cnt;
	logic [reg_addr_w-1:0] poll_addr_q;
	logic                  adc_cmd;
	logic                  go_host;
	logic                  go_poll;
	logic                  frame_end;

	function automatic logic [spi_addr_w-1:0] comm_byte(input logic [spi_addr_w-1:0] addr,
		input logic rd);
		logic [spi_addr_w-1:0] b;
		b = addr;
		b[comm_read_bit] = rd;
		return b;
	endfunction

	assign adc_cmd   = cmd_strobe && (host_cmd.target == tgt_adc);
	assign go_host   = !in_flight && spi_ready && host_pend;  // host wins.
	assign go_poll   = !in_flight && spi_ready && !host_pend && poll_pend && cfg.poll_enable;
	assign frame_end = in_flight && spi_ready && !ready_q;  // rising ready.

	always_ff @(posedge clkin) begin
		if (reset) begin
			host_pend    <= 1'b0;
			poll_pend    <= 1'b0;
			in_flight    <= 1'b0;
			owner_poll   <= 1'b0;
			ready_q      <= 1'b1;
			poll_cnt     <= '0;
			spi_start    <= 1'b0;
			busy         <= 1'b0;
			spi_done     <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			ready_q      <= spi_ready;
			spi_start    <= go_host || go_poll;
			spi_done     <= frame_end && !owner_poll;
			sample_valid <= frame_end && owner_poll;
			if (adc_cmd) begin
				host_pend <= 1'b1;
				busy      <= 1'b1;
			end else if (go_host) begin
				host_pend <= 1'b0;
			end
			if (frame_end) begin
				in_flight <= 1'b0;
				if (!owner_poll) begin
					busy <= 1'b0;  // falls together with host_done.
				end
			end else if (go_host || go_poll) begin
				in_flight  <= 1'b1;
				owner_poll <= go_poll;
			end
			if (!cfg.poll_enable || go_poll) begin
				poll_cnt  <= cfg.poll_interval;  // restart interval.
				poll_pend <= 1'b0;
			end else if (!poll_pend) begin
				if (poll_cnt == '0) begin
					poll_pend <= 1'b1;
				end else begin
					poll_cnt <= poll_cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clkin) begin
		if (adc_cmd) begin
			host_q <= host_cmd;
		end
		if (go_host) begin
			req.read <= host_q.read;
			req.addr <= comm_byte(host_q.addr, host_q.read);
			req.data <= host_q.data;
		end else if (go_poll) begin
			req.read    <= 1'b1;
			req.addr    <= comm_byte(cfg.poll_addr, 1'b1);
			req.data    <= '0;
			poll_addr_q <= cfg.poll_addr;
		end
		if (frame_end) begin
			spi_rdata    <= rsp.rdbk;
			sample.addr  <= poll_addr_q;
			sample.value <= rsp.rdbk;
		end
	end

endmodule

// File: src/adc_sub_top.sv
`timescale 1ns/1ps

module adc_sub_top #(
	parameter int tsck_half = 1,
	parameter     spi_mode  = "chain"
) (
	input  logic                           clkin,
	input  logic                           reset,
	input  logic                           cmd_strobe,
	input  adc_pkg::host_cmd_t             host_cmd,
	output logic                           host_done,
	output logic [adc_pkg::reg_data_w-1:0] host_rdata,
	output logic                           busy,
	output logic                           sample_valid,
	output adc_pkg::sample_t               sample,
	output logic                           CLK,
	output logic                           CS,
	output logic                           DIN,
	input  logic                           DOUT_RDY,
	output logic                           SCLK,
	input  logic                           sclk_in,
	input  logic                           mosi_in,
	input  logic                           spi_ssb_in,
	output logic                           spi_ssb_out,
	input  logic                           adcclk
);
	import spi_pkg::*;
	import adc_pkg::*;

	cfg_t                  cfg;
	spi_req_t              req;
	spi_rsp_t              rsp;
	logic                  spi_start;
	logic                  spi_ready;
	logic                  local_done;
	logic                  spi_done;
	logic [reg_data_w-1:0] host_rdata_local;
	logic [reg_data_w-1:0] spi_rdata;

	// local and adc completions never coincide while the host honours busy.
	assign host_done  = local_done | spi_done;
	assign host_rdata = local_done ? host_rdata_local : spi_rdata;

	adc_cfg_regs i_adc_cfg_regs (
		.clkin           (clkin),
		.reset           (reset),
		.cmd_strobe      (cmd_strobe),
		.host_cmd        (host_cmd),
		.cfg             (cfg),
		.host_rdata_local(host_rdata_local),
		.local_done      (local_done)
	);

	adc_poll_seq i_adc_poll_seq (
		.clkin       (clkin),
		.reset       (reset),
		.cmd_strobe  (cmd_strobe),
		.host_cmd    (host_cmd),
		.cfg         (cfg),
		.spi_start   (spi_start),
		.req         (req),
		.spi_ready   (spi_ready),
		.rsp         (rsp),
		.busy        (busy),
		.spi_done    (spi_done),
		.spi_rdata   (spi_rdata),
		.sample_valid(sample_valid),
		.sample      (sample)
	);

	ad7794 #(
		.tsck_half(tsck_half),
		.spi_mode (spi_mode)
	) i_ad7794 (
		.clkin      (clkin),
		.reset      (reset),
		.spi_start  (spi_start),
		.req        (req),
		.spi_ready  (spi_ready),
		.rsp        (rsp),
		.sdio_as_sdo(),
		.CLK        (CLK),
		.CS         (CS),
		.DIN        (DIN),
		.DOUT_RDY   (DOUT_RDY),
		.SCLK       (SCLK),
		.sclk_in    (sclk_in),
		.mosi_in    (mosi_in),
		.spi_ssb_in (spi_ssb_in),
		.spi_ssb_out(spi_ssb_out),
		.adcclk     (adcclk)
	);

endmodule

// File: src/spi_master.sv
`timescale 1ns/1ps

module spi_master #(
	parameter int tsck_half = 1
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              spi_start,
	input  spi_pkg::spi_req_t req,
	output logic              spi_ready,
	output spi_pkg::spi_rsp_t rsp,
	output logic              sdio_as_sdo,
	output logic              cs,
	output logic              sck,
	output logic              sdi,
	input  logic              sdo
);
	import spi_pkg::*;

	localparam int frame_w = spi_addr_w + spi_data_w;
	localparam int half_w  = $clog2(tsck_half + 1);
	localparam int bit_w   = $clog2(frame_w);

	logic [frame_w-1:0]    tx_shift;
	logic [spi_data_w-1:0] rx_shift;
	logic [spi_addr_w-1:0] addr_q;
	logic                  read_q;
	logic [half_w-1:0]     half_cnt;
	logic [bit_w-1:0]      bit_cnt;
	logic                  active;  // cs is low.
	logic                  finish;  // cs rose on the previous edge.
	logic                  launch;
	logic                  tick;
	logic                  last_bit;

	assign launch   = spi_start && spi_ready && !active;
	assign tick     = active && (half_cnt == half_w'(tsck_half - 1));
	assign last_bit = (bit_cnt == bit_w'(frame_w - 1));

	assign sdi = active & tx_shift[frame_w-1];  // msb first.
	assign sdio_as_sdo = active && read_q && (bit_cnt >= bit_w'(spi_addr_w));

	always_ff @(posedge clk) begin
		if (reset) begin
			cs        <= 1'b1;
			sck       <= 1'b0;
			spi_ready <= 1'b1;
			active    <= 1'b0;
			finish    <= 1'b0;
			half_cnt  <= '0;
			bit_cnt   <= '0;
		end else begin
			finish <= 1'b0;
			if (finish) begin
				spi_ready <= 1'b1;  // rsp is already stable here.
			end
			if (launch) begin
				active    <= 1'b1;
				cs        <= 1'b0;
				spi_ready <= 1'b0;
				half_cnt  <= '0;
				bit_cnt   <= '0;
			end else if (active) begin
				if (tick) begin
					half_cnt <= '0;
					sck      <= ~sck;
					if (sck) begin  // falling edge closes a bit period
						if (last_bit) begin
							active <= 1'b0;
							cs     <= 1'b1;
							finish <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

	// shift registers and response.
	always_ff @(posedge clk) begin
		if (launch) begin
			tx_shift <= {req.addr, req.data};
			addr_q   <= req.addr;
			read_q   <= req.read;
		end else if (tick) begin
			if (!sck) begin
				rx_shift <= {rx_shift[spi_data_w-2:0], sdo};  // sample on rising sck.
			end else begin
				tx_shift <= {tx_shift[frame_w-2:0], 1'b0};  // next bit on falling sck.
			end
			if (sck && last_bit) begin
				rsp.sdo_addr <= addr_q;
				rsp.rdbk     <= rx_shift;
			end
		end
	end

endmodule

// File: src/spi_pkg.sv
package spi_pkg;

	localparam int spi_addr_w = 8;   // communications byte.
	localparam int spi_data_w = 24;  // widest ad7794 register.

	// one frame as requested by the sequencer.
	typedef struct packed {
		logic                  read;  // data phase is driven by the adc.
		logic [spi_addr_w-1:0] addr;  // communications byte, sent first.
		logic [spi_data_w-1:0] data;  // write data, don't care on reads.
	} spi_req_t;

	// result of the last finished frame, held until the next one ends.
	typedef struct packed {
		logic [spi_addr_w-1:0] sdo_addr;  // address byte that went out.
		logic [spi_data_w-1:0] rdbk;      // bits sampled in the data phase.
	} spi_rsp_t;

endpackage
